//--- files.f
+incdir+sim
logic/coalescer_cfg_pkg.sv
logic/coalescer_types_pkg.sv
logic/lane_addr_gen.sv
logic/block_tag_match.sv
logic/lane_sequencer.sv
logic/store_packer.sv
logic/vmem_coalescer.sv
sim/tb_vmem_coalescer.sv

//--- logic/block_tag_match.sv
`timescale 1ns/1ps

module block_tag_match (
    input  coalescer_types_pkg::lane_words_t sel_addr,
    input  coalescer_types_pkg::lane_idx_t   curr_lane,
    input  logic                             indexed,
    input  logic                             mem_wen,
    output coalescer_types_pkg::lane_vec_t   en_lanes
);

    import coalescer_cfg_pkg::*;
    import coalescer_types_pkg::*;

    logic [WORD_SIZE-TAG_LSB-1:0] curr_tag;
    logic                         coalesce;

    // block tag of the address being issued
    assign curr_tag = sel_addr[curr_lane][WORD_SIZE-1:TAG_LSB];

    // strided stores go out one lane at a time
    assign coalesce = indexed || !mem_wen;

    always_comb begin
        en_lanes = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (k == int'(curr_lane)) begin
                en_lanes[k] = 1'b1;
            end else if (coalesce && k > int'(curr_lane)) begin
                // higher lanes join when they hit the same block
                en_lanes[k] = (sel_addr[k][WORD_SIZE-1:TAG_LSB] == curr_tag);
            end
        end
    end

endmodule

//--- logic/coalescer_cfg_pkg.sv
package coalescer_cfg_pkg;

    // vector unit geometry
    localparam int NUM_LANES = 4;

    // address and data path width in bits
    localparam int WORD_SIZE = 32;

    // data cache block shape as seen by the load/store unit
    localparam int BLOCK_WORDS = 4;

    // word index bits inside one block
    localparam int BLOCK_BITS = 2;

    // lowest address bit that belongs to the block tag
    // two byte-offset bits sit below the word index
    localparam int TAG_LSB = BLOCK_BITS + 2;

endpackage

//--- logic/coalescer_types_pkg.sv
package coalescer_types_pkg;

    import coalescer_cfg_pkg::*;

    // one address or data word
    typedef logic [WORD_SIZE-1:0] word_t;

    // lane number
    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

    // one bit per lane, for masks and enables
    typedef logic [NUM_LANES-1:0] lane_vec_t;

    // one word per lane
    typedef word_t [NUM_LANES-1:0] lane_words_t;

    // one word per slot of a cache block
    typedef word_t [BLOCK_WORDS-1:0] block_data_t;

    // element width of the vector micro-op
    typedef enum logic [1:0] {SEW8, SEW16, SEW32} eew_t;

    // load type handed to the load/store unit
    typedef enum logic [1:0] {LB, LH, LW} load_type_t;

    // lane currently being issued
    typedef enum logic [$clog2(NUM_LANES)-1:0] {VL0, VL1, VL2, VL3} lane_state_t;

endpackage

//--- logic/lane_addr_gen.sv
`timescale 1ns/1ps

module lane_addr_gen (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             flush,
    input  logic                             indexed,
    input  logic                             uop_first,
    input  coalescer_types_pkg::word_t       base,
    input  coalescer_types_pkg::word_t       stride,
    input  coalescer_types_pkg::lane_words_t lane_addr,
    input  logic                             load_uop,
    input  logic                             advance_uop,
    output coalescer_types_pkg::lane_words_t sel_addr
);

    import coalescer_cfg_pkg::*;
    import coalescer_types_pkg::*;

    lane_words_t strided_q;
    lane_words_t first_addr;
    lane_words_t cur_strided;
    lane_words_t next_strided;

    // lane k of a new instruction starts at base + k * stride
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            first_addr[k] = base + stride * word_t'(k);
        end
    end

    // the first micro-op uses the fresh addresses in the same cycle
    assign cur_strided = (load_uop && uop_first) ? first_addr : strided_q;

    always_comb begin
        next_strided = strided_q;
        if (advance_uop) begin
            // next micro-op continues four elements further on
            for (int k = 0; k < NUM_LANES; k++) begin
                next_strided[k] = cur_strided[k] + (stride << 2);
            end
        end else if (load_uop && uop_first) begin
            next_strided = first_addr;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            strided_q <= '0;
        end else if (flush) begin
            strided_q <= '0;
        end else begin
            strided_q <= next_strided;
        end
    end

    assign sel_addr = indexed ? lane_addr : cur_strided;

    // a flushed micro-op must not move the strided addresses on
    assert property (@(posedge CLK) disable iff (!nRST) flush |-> !advance_uop)
        else $error("lane addresses advanced during flush");

endmodule

//--- logic/lane_sequencer.sv
`timescale 1ns/1ps

module lane_sequencer (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             flush,
    input  logic                             mem_ren,
    input  logic                             mem_wen,
    input  coalescer_types_pkg::lane_vec_t   lane_mask,
    input  coalescer_types_pkg::lane_vec_t   en_lanes,
    input  coalescer_types_pkg::lane_words_t sel_addr,
    input  coalescer_types_pkg::eew_t        eew,
    input  logic                             lsc_ready,
    output coalescer_types_pkg::lane_idx_t   curr_lane,
    output coalescer_types_pkg::word_t       lsc_addr,
    output logic                             lsc_ren,
    output logic                             lsc_wen,
    output logic                             last_lane,
    output logic                             stall,
    output logic                             load_uop,
    output logic                             advance_uop,
    output coalescer_types_pkg::load_type_t  load_type
);

    import coalescer_cfg_pkg::*;
    import coalescer_types_pkg::*;

    lane_state_t state;
    lane_state_t next_state;
    logic        req;
    logic        lane_active;
    logic        lane_done;
    logic        uop_end;
    logic        next_found;
    lane_idx_t   next_idx;

    assign req         = mem_ren || mem_wen;
    assign curr_lane   = lane_idx_t'(state);
    assign lsc_addr    = sel_addr[curr_lane];
    assign lane_active = lane_mask[curr_lane];

    // masked lanes never reach the load/store unit
    assign lsc_ren = mem_ren && lane_active;
    assign lsc_wen = mem_wen && lane_active;

    // a masked lane retires without waiting for lsc_ready
    assign lane_done = req && (lsc_ready || !lane_active);

    // lowest lane above the current one that this access does not cover
    always_comb begin
        next_found = 1'b0;
        next_idx   = curr_lane;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (k > int'(curr_lane) && !en_lanes[k]) begin
                next_found = 1'b1;
                next_idx   = lane_idx_t'(k);
            end
        end
    end

    assign last_lane = !next_found;
    assign uop_end   = lane_done && last_lane;
    assign stall     = req && !uop_end;

    // strided addresses for a new micro-op are taken while in VL0
    assign load_uop    = req && (state == VL0);
    assign advance_uop = uop_end && !flush;

    always_comb begin
        next_state = state;
        if (lane_done) begin
            next_state = last_lane ? VL0 : lane_state_t'(next_idx);
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= VL0;
        end else if (flush) begin
            state <= VL0;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (eew)
            SEW8:    load_type = LB;
            SEW16:   load_type = LH;
            default: load_type = LW;
        endcase
    end

    // issue stage must never request a load and a store together
    assert property (@(posedge CLK) disable iff (!nRST) !(lsc_ren && lsc_wen))
        else $error("lsc_ren and lsc_wen high together");

endmodule

//--- logic/store_packer.sv
`timescale 1ns/1ps

module store_packer (
    input  coalescer_types_pkg::lane_vec_t    en_lanes,
    input  coalescer_types_pkg::lane_words_t  sel_addr,
    input  coalescer_types_pkg::lane_words_t  lane_store_data,
    input  coalescer_types_pkg::lane_idx_t    curr_lane,
    output coalescer_types_pkg::block_data_t  wide_store_data,
    output coalescer_types_pkg::word_t        single_store_data
);

    import coalescer_cfg_pkg::*;
    import coalescer_types_pkg::*;

    logic [BLOCK_BITS-1:0] slot [NUM_LANES];

    // word slot of each lane inside its block
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            slot[k] = sel_addr[k][TAG_LSB-1:TAG_LSB-BLOCK_BITS];
        end
    end

    always_comb begin
        wide_store_data = '0;
        // ascending order, so a higher lane overwrites a shared slot
        for (int k = 0; k < NUM_LANES; k++) begin
            if (en_lanes[k]) begin
                wide_store_data[slot[k]] = lane_store_data[k];
            end
        end
    end

    // single-word path for uncoalesced stores
    assign single_store_data = lane_store_data[curr_lane];

endmodule

//--- logic/vmem_coalescer.sv
`timescale 1ns/1ps

module vmem_coalescer (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              flush,
    input  logic                              mem_ren,
    input  logic                              mem_wen,
    input  logic                              indexed,
    input  logic                              uop_first,
    input  coalescer_types_pkg::word_t        base,
    input  coalescer_types_pkg::word_t        stride,
    input  coalescer_types_pkg::lane_words_t  lane_addr,
    input  coalescer_types_pkg::lane_vec_t    lane_mask,
    input  coalescer_types_pkg::lane_words_t  lane_store_data,
    input  coalescer_types_pkg::eew_t         eew,
    input  logic                              lsc_ready,
    output logic                              stall,
    output coalescer_types_pkg::word_t        lsc_addr,
    output logic                              lsc_ren,
    output logic                              lsc_wen,
    output coalescer_types_pkg::lane_vec_t    en_lanes,
    output coalescer_types_pkg::lane_idx_t    curr_lane,
    output logic                              last_lane,
    output coalescer_types_pkg::lane_words_t  wide_addr,
    output coalescer_types_pkg::block_data_t  wide_store_data,
    output coalescer_types_pkg::word_t        single_store_data,
    output coalescer_types_pkg::load_type_t   load_type
);

    import coalescer_cfg_pkg::*;
    import coalescer_types_pkg::*;

    logic load_uop;
    logic advance_uop;

    // wide_addr doubles as the selected lane address vector
    lane_addr_gen u_addr_gen (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .indexed     (indexed),
        .uop_first   (uop_first),
        .base        (base),
        .stride      (stride),
        .lane_addr   (lane_addr),
        .load_uop    (load_uop),
        .advance_uop (advance_uop),
        .sel_addr    (wide_addr)
    );

    block_tag_match u_tag_match (
        .sel_addr  (wide_addr),
        .curr_lane (curr_lane),
        .indexed   (indexed),
        .mem_wen   (mem_wen),
        .en_lanes  (en_lanes)
    );

    lane_sequencer u_sequencer (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .lane_mask   (lane_mask),
        .en_lanes    (en_lanes),
        .sel_addr    (wide_addr),
        .eew         (eew),
        .lsc_ready   (lsc_ready),
        .curr_lane   (curr_lane),
        .lsc_addr    (lsc_addr),
        .lsc_ren     (lsc_ren),
        .lsc_wen     (lsc_wen),
        .last_lane   (last_lane),
        .stall       (stall),
        .load_uop    (load_uop),
        .advance_uop (advance_uop),
        .load_type   (load_type)
    );

    store_packer u_packer (
        .en_lanes          (en_lanes),
        .sel_addr          (wide_addr),
        .lane_store_data   (lane_store_data),
        .curr_lane         (curr_lane),
        .wide_store_data   (wide_store_data),
        .single_store_data (single_store_data)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the coalescer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vmem_coalescer -f files.f -o tb_vmem_coalescer

./obj_dir/tb_vmem_coalescer > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sim/coalescer_checks.svh
`ifndef COALESCER_CHECKS_SVH
`define COALESCER_CHECKS_SVH

// lane addresses of micro-op n of a strided instruction
function automatic lane_words_t strided_addrs(input word_t b, input word_t s, input int n);
    lane_words_t a;
    for (int k = 0; k < 4; k++) begin
        a[lane_idx_t'(k)] = b + s * word_t'(4 * n + k);
    end
    return a;
endfunction

// current lane plus every higher lane that falls in the same four-word block
function automatic lane_vec_t enables_for(input lane_words_t a, input lane_idx_t cur,
                                          input logic idx, input logic wen);
    lane_vec_t en;
    word_t     cur_addr;
    word_t     lane_a;
    en = '0;
    en[cur] = 1'b1;
    cur_addr = a[cur];
    for (int k = 0; k < 4; k++) begin
        lane_a = a[lane_idx_t'(k)];
        // strided stores never coalesce
        if (k > int'(cur) && (idx || !wen) && lane_a[31:4] == cur_addr[31:4]) begin
            en[lane_idx_t'(k)] = 1'b1;
        end
    end
    return en;
endfunction

// lowest lane above cur left out of the access, -1 when the micro-op is done
function automatic int next_uncovered_lane(input lane_vec_t en, input lane_idx_t cur);
    int nxt;
    nxt = -1;
    for (int k = 3; k >= 0; k--) begin
        if (k > int'(cur) && !en[lane_idx_t'(k)]) begin
            nxt = k;
        end
    end
    return nxt;
endfunction

// store words dropped into their block slots, later lanes win
function automatic block_data_t packed_block(input lane_words_t a, input lane_words_t d,
                                             input lane_vec_t en);
    block_data_t blk;
    word_t       lane_a;
    blk = '0;
    for (int k = 0; k < 4; k++) begin
        lane_a = a[lane_idx_t'(k)];
        if (en[lane_idx_t'(k)]) begin
            blk[lane_a[3:2]] = d[lane_idx_t'(k)];
        end
    end
    return blk;
endfunction

function automatic load_type_t expected_load_type(input eew_t e);
    case (e)
        SEW8:    return LB;
        SEW16:   return LH;
        default: return LW;
    endcase
endfunction

// no request means no stall and no memory enable
idle_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_ren || mem_wen) |-> (!stall && !lsc_ren && !lsc_wen))
    else begin
        errors++;
        $display("stall or a memory enable was high without a request");
    end

masked_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    !lane_mask[curr_lane] |-> (!lsc_ren && !lsc_wen))
    else begin
        errors++;
        $display("a masked lane reached the load/store unit");
    end

// back-pressure on an active lane freezes the issued access
backpressure_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !lsc_ready && lane_mask[curr_lane] && !flush)
        |=> ($stable(curr_lane) && $stable(lsc_addr)))
    else begin
        errors++;
        $display("current lane or address moved while the load/store unit was not ready");
    end

current_enabled: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_ren || mem_wen) |-> en_lanes[curr_lane])
    else begin
        errors++;
        $display("the current lane was left out of its own access");
    end

`endif

//--- sim/tb_vmem_coalescer.sv
`timescale 1ns/1ps

module tb_vmem_coalescer;

    import coalescer_cfg_pkg::*;
    import coalescer_types_pkg::*;

    typedef logic [127:0] wide_t;

    localparam int NUM_TESTS  = 7;
    localparam int UOP_LIMIT  = 40;
    localparam int CLK_PERIOD = 4;

    logic        CLK;
    logic        nRST;
    logic        flush;
    logic        mem_ren;
    logic        mem_wen;
    logic        indexed;
    logic        uop_first;
    word_t       base;
    word_t       stride;
    lane_words_t lane_addr;
    lane_vec_t   lane_mask;
    lane_words_t lane_store_data;
    eew_t        eew;
    logic        lsc_ready;
    logic        stall;
    word_t       lsc_addr;
    logic        lsc_ren;
    logic        lsc_wen;
    lane_vec_t   en_lanes;
    lane_idx_t   curr_lane;
    logic        last_lane;
    lane_words_t wide_addr;
    block_data_t wide_store_data;
    word_t       single_store_data;
    load_type_t  load_type;

    int          seed;
    int          errors;
    int          errors_before;
    int          test_num;
    int          passed;
    int          failed;
    word_t       b;
    lane_words_t addrs;

    vmem_coalescer dut (.*);

    `include "coalescer_checks.svh"

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // 40 cycles per test on top of reset
    initial begin
        #((NUM_TESTS * UOP_LIMIT + 8) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic expect_value(input string name, input wide_t exp, input wide_t got);
        assert (got === exp)
        else begin
            errors++;
            $display("mismatch %s expected 0x%0h got 0x%0h", name, exp, got);
        end
    endtask

    task automatic drive_request(input logic ren, input logic wen, input logic idx,
                                 input logic first, input word_t bs, input word_t s,
                                 input lane_vec_t mask, input eew_t e);
        mem_ren   = ren;
        mem_wen   = wen;
        indexed   = idx;
        uop_first = first;
        base      = bs;
        stride    = s;
        lane_mask = mask;
        eew       = e;
    endtask

    task automatic drive_idle();
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        uop_first = 1'b0;
        lsc_ready = 1'b0;
    endtask

    // walks one micro-op until stall drops and checks every cycle against the model
    task automatic run_uop(input lane_words_t a, input int hold);
        lane_idx_t cur;
        lane_vec_t en;
        int        nxt;
        int        cycles;
        int        wait_left;
        logic      complete;
        logic      ended;
        cur       = '0;
        cycles    = 0;
        wait_left = hold;
        ended     = 1'b0;
        while (!ended && cycles < UOP_LIMIT) begin
            lsc_ready = (wait_left == 0) && lane_mask[cur];
            #1;
            en       = enables_for(a, cur, indexed, mem_wen);
            nxt      = next_uncovered_lane(en, cur);
            complete = lsc_ready || !lane_mask[cur];
            expect_value("curr_lane", wide_t'(cur), wide_t'(curr_lane));
            expect_value("lsc_addr", wide_t'(a[cur]), wide_t'(lsc_addr));
            expect_value("wide_addr", wide_t'(a), wide_t'(wide_addr));
            expect_value("en_lanes", wide_t'(en), wide_t'(en_lanes));
            expect_value("last_lane", wide_t'(nxt < 0), wide_t'(last_lane));
            expect_value("lsc_ren", wide_t'(mem_ren && lane_mask[cur]), wide_t'(lsc_ren));
            expect_value("lsc_wen", wide_t'(mem_wen && lane_mask[cur]), wide_t'(lsc_wen));
            expect_value("stall", wide_t'(!(complete && nxt < 0)), wide_t'(stall));
            expect_value("wide_store_data", wide_t'(packed_block(a, lane_store_data, en)),
                         wide_t'(wide_store_data));
            expect_value("single_store_data", wide_t'(lane_store_data[cur]),
                         wide_t'(single_store_data));
            expect_value("load_type", wide_t'(expected_load_type(eew)), wide_t'(load_type));
            ended = !stall;
            @(negedge CLK);
            cycles++;
            if (wait_left > 0 && lane_mask[cur]) begin
                wait_left--;
            end
            if (complete && nxt >= 0) begin
                cur = lane_idx_t'(nxt);
            end
        end
        if (!ended) begin
            errors++;
            $display("micro-op did not end within %0d cycles", UOP_LIMIT);
        end
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (errors == errors_before) begin
            passed++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            failed++;
            $display("test %0d %s: fail", test_num, name);
        end
        errors_before = errors;
        drive_idle();
        @(negedge CLK);
    endtask

    initial begin
        seed = 25;
        {errors, errors_before, test_num, passed, failed} = '0;
        nRST = 1'b0;
        flush = 1'b0;
        drive_request(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, SEW32);
        lane_addr = '0;
        lane_store_data = '0;
        lsc_ready = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        repeat (3) begin
            #1;
            expect_value("stall", '0, wide_t'(stall));
            expect_value("lsc_ren", '0, wide_t'(lsc_ren));
            expect_value("lsc_wen", '0, wide_t'(lsc_wen));
            expect_value("curr_lane", '0, wide_t'(curr_lane));
            @(negedge CLK);
        end
        finish_test("idle after reset");

        // whole micro-op in one block and the next one 16 bytes on
        b = word_t'($random(seed)) & 32'hFFFF_FFF0;
        drive_request(1'b1, 1'b0, 1'b0, 1'b1, b, 32'd4, 4'b1111, SEW32);
        run_uop(strided_addrs(b, 32'd4, 0), 0);
        uop_first = 1'b0;
        run_uop(strided_addrs(b, 32'd4, 1), 0);
        finish_test("unit-stride load");

        b = word_t'($random(seed)) & 32'hFFFF_FFFC;
        drive_request(1'b1, 1'b0, 1'b0, 1'b1, b, 32'd16, 4'b1111, SEW32);
        run_uop(strided_addrs(b, 32'd16, 0), 0);
        uop_first = 1'b0;
        run_uop(strided_addrs(b, 32'd16, 1), 0);
        finish_test("wide-stride load");

        // lanes 0 and 2 share one block and lanes 1 and 3 another
        b = word_t'($random(seed)) & 32'hFFFF_FFC0;
        addrs[0] = b + 32'd4;
        addrs[1] = b + 32'd32;
        addrs[2] = b + 32'd12;
        addrs[3] = b + 32'd40;
        lane_addr = addrs;
        for (int k = 0; k < 4; k++) begin
            lane_store_data[lane_idx_t'(k)] = word_t'($random(seed));
        end
        drive_request(1'b0, 1'b1, 1'b1, 1'b1, '0, '0, 4'b1111, SEW32);
        run_uop(addrs, 0);
        finish_test("indexed store");

        b = word_t'($random(seed)) & 32'hFFFF_FFFC;
        drive_request(1'b1, 1'b0, 1'b0, 1'b1, b, 32'd16, 4'b1011, SEW32);
        run_uop(strided_addrs(b, 32'd16, 0), 3);
        finish_test("back-pressure and masking");

        // flush on lane 1 sends the sequencer back to lane 0 with zeroed strided addresses
        b = word_t'($random(seed)) & 32'hFFFF_FFFC;
        drive_request(1'b1, 1'b0, 1'b0, 1'b1, b, 32'd16, 4'b1111, SEW32);
        lsc_ready = 1'b1;
        @(negedge CLK);
        flush = 1'b1;
        #1;
        expect_value("curr_lane", wide_t'(1), wide_t'(curr_lane));
        @(negedge CLK);
        flush = 1'b0;
        uop_first = 1'b0;
        run_uop('0, 0);
        finish_test("flush");

        b = word_t'($random(seed)) & 32'hFFFF_FFF0;
        drive_request(1'b1, 1'b0, 1'b0, 1'b1, b, 32'd4, 4'b1111, SEW8);
        run_uop(strided_addrs(b, 32'd4, 0), 0);
        eew = SEW16;
        run_uop(strided_addrs(b, 32'd4, 0), 0);
        eew = SEW32;
        run_uop(strided_addrs(b, 32'd4, 0), 0);
        finish_test("load type");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 test_num, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
